/* mem_pkg.sv */
package mem_pkg;

	// Byte address into the shared memory
	typedef logic [7:0] addr_t;

	// Byte stored in the shared memory
	typedef logic [7:0] mem_data_t;

	// Shared memory size in bytes
	localparam int MEM_DEPTH = 256;

	// Data cache lines, one byte each
	localparam int CACHE_ENTRIES = 4;

	// Age of a cache line
	// 0 is most recently used
	typedef logic [1:0] lru_t;

	// Memory port owners as seen by the arbiter
	typedef logic [1:0] req_id_t;
	localparam req_id_t REQ_NONE  = 2'd0;
	localparam req_id_t REQ_LOAD  = 2'd1;
	localparam req_id_t REQ_CACHE = 2'd2;
	localparam req_id_t REQ_FETCH = 2'd3;

endpackage

/* cpu_pkg.sv */
package cpu_pkg;

	////////////////////////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////////////////////////

	// Accumulator, ALU operand and device bus word
	typedef logic [7:0] word_t;

	// One condition code bit
	typedef logic flag_t;

	// Interrupt level
	// Level 0 wins over every other level
	typedef logic [1:0] irq_level_t;

	////////////////////////////////////////////////////////////
	// Instruction set
	////////////////////////////////////////////////////////////

	// Opcode byte of each two-byte instruction
	// Codes not listed here execute as NOP
	typedef enum logic [7:0] {
		NOP  = 8'h00,
		LDI  = 8'h01,
		LDM  = 8'h02,
		STM  = 8'h03,
		ADDI = 8'h04,
		ADDM = 8'h05,
		SUBI = 8'h06,
		ANDI = 8'h07,
		ORI  = 8'h08,
		XORI = 8'h09,
		SHL  = 8'h0A,
		SHR  = 8'h0B,
		IN   = 8'h0C,
		OUT  = 8'h0D,
		JMP  = 8'h0E,
		JZ   = 8'h0F,
		EI   = 8'h10,
		RETI = 8'h11,
		HALT = 8'hFF
	} opcode_t;

	// Interrupt request lines, one mask bit each
	localparam int IRQ_LINES = 4;

	// Level 0 handler address
	localparam word_t VECTOR_BASE = 8'hE0;
	// Bytes between handlers of adjacent levels
	localparam int VECTOR_STRIDE = 8;

	// First fetch address after reset
	localparam word_t RESET_PC = 8'h00;

endpackage

/* mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
	input  logic               g_clk,
	input  logic               rst_n,
	input  logic               load_en,
	input  mem_pkg::addr_t     load_addr,
	input  mem_pkg::mem_data_t load_data,
	input  logic               dc_mem_req,
	input  logic               dc_mem_we,
	input  mem_pkg::addr_t     dc_mem_addr,
	input  mem_pkg::mem_data_t dc_mem_wdata,
	output logic               dc_mem_gnt,
	input  logic               if_mem_req,
	input  mem_pkg::addr_t     if_mem_addr,
	output logic               if_mem_gnt,
	output logic               ram_we,
	output mem_pkg::addr_t     ram_addr,
	output mem_pkg::mem_data_t ram_wdata
);

	mem_pkg::req_id_t winner;

	// Fixed priority, load port first
	// A peer whose grant is showing still holds its request, skip it
	always_comb begin
		if (load_en)
			winner = mem_pkg::REQ_LOAD;
		else if (dc_mem_req && !dc_mem_gnt)
			winner = mem_pkg::REQ_CACHE;
		else if (if_mem_req && !if_mem_gnt)
			winner = mem_pkg::REQ_FETCH;
		else
			winner = mem_pkg::REQ_NONE;
	end

	// Winner drives the single memory port this cycle
	always_comb begin
		ram_we    = 1'b0;
		ram_addr  = if_mem_addr;
		ram_wdata = dc_mem_wdata;
		case (winner)
			mem_pkg::REQ_LOAD: begin
				ram_we    = 1'b1;
				ram_addr  = load_addr;
				ram_wdata = load_data;
			end
			mem_pkg::REQ_CACHE: begin
				ram_we   = dc_mem_we;
				ram_addr = dc_mem_addr;
			end
			default: ;
		endcase
	end

	// Grant shows up together with the read data
	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			dc_mem_gnt <= 1'b0;
			if_mem_gnt <= 1'b0;
		end else begin
			dc_mem_gnt <= (winner == mem_pkg::REQ_CACHE);
			if_mem_gnt <= (winner == mem_pkg::REQ_FETCH);
		end
	end

	a_one_grant: assert property (@(posedge g_clk) disable iff (!rst_n)
		!(dc_mem_gnt && if_mem_gnt))
		else $error("cache and fetch granted in the same cycle");

	a_gnt_had_req: assert property (@(posedge g_clk) disable iff (!rst_n)
		(dc_mem_gnt |-> $past(dc_mem_req)) and (if_mem_gnt |-> $past(if_mem_req)))
		else $error("grant without a request in the previous cycle");

endmodule

/* unified_ram.sv */
`timescale 1ns/10ps

module unified_ram (
	input  logic               g_clk,
	input  logic               we,
	input  mem_pkg::addr_t     addr,
	input  mem_pkg::mem_data_t wdata,
	output mem_pkg::mem_data_t rdata
);

	// Program and data share one array
	mem_pkg::mem_data_t mem [mem_pkg::MEM_DEPTH];

	// Read returns the old byte on a write cycle
	always_ff @(posedge g_clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* data_cache.sv */
`timescale 1ns/10ps

module data_cache (
	input  logic               g_clk,
	input  logic               rst_n,
	input  logic               dc_req,
	input  logic               dc_we,
	input  mem_pkg::addr_t     dc_addr,
	input  mem_pkg::mem_data_t dc_wdata,
	output logic               dc_done,
	output mem_pkg::mem_data_t dc_rdata,
	output logic               cache_hit,
	output logic               dc_mem_req,
	output logic               dc_mem_we,
	output mem_pkg::addr_t     dc_mem_addr,
	output mem_pkg::mem_data_t dc_mem_wdata,
	input  logic               dc_mem_gnt,
	input  mem_pkg::mem_data_t mem_rdata
);

	localparam int N = mem_pkg::CACHE_ENTRIES;

	typedef enum logic {C_IDLE, C_MEM} cache_state_t;

	cache_state_t       state;
	mem_pkg::addr_t     tag [N];
	mem_pkg::mem_data_t data [N];
	mem_pkg::lru_t      age [N];
	logic [N-1:0]       valid;
	logic               hit;
	logic [$clog2(N)-1:0] hit_idx;
	logic [$clog2(N)-1:0] victim;
	logic [$clog2(N)-1:0] touch_idx;
	logic               touch;
	logic               start;
	logic               read_hit;
	logic               finish;

	////////////////////////////////////////////////////////////
	// Lookup and replacement
	////////////////////////////////////////////////////////////

	// Tag compare on the live address
	// Execute holds it until dc_done
	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < N; i++) begin
			if (valid[i] && tag[i] == dc_addr) begin
				hit     = 1'b1;
				hit_idx = i[$clog2(N)-1:0];
			end
		end
	end

	// Lowest empty line, else the oldest one
	always_comb begin
		victim = '0;
		for (int i = 0; i < N; i++)
			if (age[i] == '1)
				victim = i[$clog2(N)-1:0];
		for (int i = N - 1; i >= 0; i--)
			if (!valid[i])
				victim = i[$clog2(N)-1:0];
	end

	// Ignore the held request in its done cycle
	assign start    = (state == C_IDLE) && dc_req && !dc_done;
	assign read_hit = start && !dc_we && hit;
	assign finish   = (state == C_MEM) && dc_mem_gnt;
	assign dc_mem_req = (state == C_MEM);

	// Fill and read hit age the used line, write hit too
	assign touch_idx = (finish && !dc_mem_we) ? victim : hit_idx;
	assign touch     = read_hit || (finish && (!dc_mem_we || hit));

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= C_IDLE;
			dc_done   <= 1'b0;
			cache_hit <= 1'b0;
			valid     <= '0;
			for (int i = 0; i < N; i++)
				age[i] <= mem_pkg::lru_t'(i);
		end else begin
			dc_done   <= read_hit || finish;
			cache_hit <= read_hit;
			if (start && !read_hit)
				state <= C_MEM;
			else if (finish)
				state <= C_IDLE;
			if (finish && !dc_mem_we)
				valid[victim] <= 1'b1;
			// Younger lines than the touched one grow older
			if (touch) begin
				for (int i = 0; i < N; i++)
					if (age[i] < age[touch_idx])
						age[i] <= age[i] + 1'b1;
				age[touch_idx] <= '0;
			end
		end
	end

	// Line contents and the latched memory access
	always_ff @(posedge g_clk) begin
		if (start) begin
			dc_mem_we    <= dc_we;
			dc_mem_addr  <= dc_addr;
			dc_mem_wdata <= dc_wdata;
		end
		if (read_hit)
			dc_rdata <= data[hit_idx];
		if (finish && !dc_mem_we) begin
			dc_rdata     <= mem_rdata;
			tag[victim]  <= dc_mem_addr;
			data[victim] <= mem_rdata;
		end
		// Write-through keeps a hitting line current
		if (finish && dc_mem_we && hit)
			data[hit_idx] <= dc_mem_wdata;
	end

	a_hit_no_mem: assert property (@(posedge g_clk) disable iff (!rst_n)
		read_hit |=> !dc_mem_req)
		else $error("read hit went to memory");

endmodule

/* fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
	input  logic             g_clk,
	input  logic             rst_n,
	input  logic             run,
	input  logic             redirect,
	input  mem_pkg::addr_t   redirect_pc,
	input  logic             if_mem_gnt,
	input  mem_pkg::mem_data_t mem_rdata,
	input  logic             instr_taken,
	output logic             if_mem_req,
	output mem_pkg::addr_t   if_mem_addr,
	output logic             instr_valid,
	output cpu_pkg::opcode_t opcode,
	output cpu_pkg::word_t   operand,
	output mem_pkg::addr_t   next_pc
);

	// Opcode byte, operand byte, then hold for execute
	typedef enum logic [1:0] {F_IDLE, F_OP, F_ARG, F_FULL} fetch_state_t;

	fetch_state_t   state;
	mem_pkg::addr_t pc;

	// Redirect wins over everything
	// A pass through F_IDLE swallows a grant still in flight
	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= F_IDLE;
			pc    <= cpu_pkg::RESET_PC;
		end else if (redirect) begin
			state <= F_IDLE;
			pc    <= redirect_pc;
		end else begin
			case (state)
				F_IDLE: if (run) state <= F_OP;
				F_OP: if (if_mem_gnt) begin
					state <= F_ARG;
					pc    <= pc + 1'b1;
				end
				F_ARG: if (if_mem_gnt) begin
					state <= F_FULL;
					pc    <= pc + 1'b1;
				end
				F_FULL: if (instr_taken) state <= F_OP;
				default: state <= F_IDLE;
			endcase
		end
	end

	// Instruction bytes arrive with the grant
	always_ff @(posedge g_clk) begin
		if (state == F_OP && if_mem_gnt)
			opcode <= cpu_pkg::opcode_t'(mem_rdata);
		if (state == F_ARG && if_mem_gnt)
			operand <= mem_rdata;
	end

	assign if_mem_req  = (state == F_OP) || (state == F_ARG);
	assign if_mem_addr = pc;
	assign instr_valid = (state == F_FULL);
	// PC already points past the held instruction
	assign next_pc     = pc;

	a_redirect_flush: assert property (@(posedge g_clk) disable iff (!rst_n)
		redirect |=> !instr_valid)
		else $error("instruction survived a redirect");

endmodule

/* interrupt_ctrl.sv */
`timescale 1ns/10ps

module interrupt_ctrl (
	input  logic                            g_clk,
	input  logic                            rst_n,
	input  logic [cpu_pkg::IRQ_LINES-1:0]   irq,
	input  logic                            mask_we,
	input  logic [cpu_pkg::IRQ_LINES-1:0]   mask_data,
	input  logic                            irq_ack,
	input  logic                            irq_done,
	output logic                            irq_pending,
	output cpu_pkg::irq_level_t             irq_level
);

	localparam int N = cpu_pkg::IRQ_LINES;

	logic [N-1:0] irq_q;
	logic [N-1:0] req;
	logic [N-1:0] mask;
	logic [N-1:0] active;
	logic [N-1:0] ack_clr;
	logic         in_service;

	// Requests stay latched while masked
	assign active = req & mask;

	// Lowest numbered enabled request wins
	always_comb begin
		irq_level = '0;
		for (int i = N - 1; i >= 0; i--)
			if (active[i])
				irq_level = cpu_pkg::irq_level_t'(i);
	end

	// One level at a time
	assign irq_pending = (|active) && !in_service;

	// Served line drops its request
	assign ack_clr = irq_ack ? ({{(N-1){1'b0}}, 1'b1} << irq_level) : '0;

	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_q      <= '0;
			req        <= '0;
			mask       <= '0;
			in_service <= 1'b0;
		end else begin
			irq_q <= irq;
			// Rising edges only
			req   <= (req | (irq & ~irq_q)) & ~ack_clr;
			if (mask_we)
				mask <= mask_data;
			if (irq_ack)
				in_service <= 1'b1;
			else if (irq_done)
				in_service <= 1'b0;
		end
	end

	a_ack_pending: assert property (@(posedge g_clk) disable iff (!rst_n)
		irq_ack |-> irq_pending)
		else $error("vector taken with no request pending");

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
	input  logic                          g_clk,
	input  logic                          rst_n,
	input  logic                          instr_valid,
	input  cpu_pkg::opcode_t              opcode,
	input  cpu_pkg::word_t                operand,
	input  mem_pkg::addr_t                next_pc,
	output logic                          instr_taken,
	output logic                          redirect,
	output mem_pkg::addr_t                redirect_pc,
	output logic                          dc_req,
	output logic                          dc_we,
	output mem_pkg::addr_t                dc_addr,
	output mem_pkg::mem_data_t            dc_wdata,
	input  logic                          dc_done,
	input  mem_pkg::mem_data_t            dc_rdata,
	input  logic                          irq_pending,
	input  cpu_pkg::irq_level_t           irq_level,
	output logic                          irq_ack,
	output logic                          irq_done,
	output logic                          mask_we,
	output logic [cpu_pkg::IRQ_LINES-1:0] mask_data,
	input  logic                          in_dev_hs,
	input  cpu_pkg::word_t                input_bus,
	input  logic                          out_dev_hs,
	input  logic                          out_dev_ack,
	output logic                          in_dev_ack,
	output logic                          out_dev_req,
	output cpu_pkg::word_t                output_bus,
	output cpu_pkg::word_t                acc,
	output cpu_pkg::flag_t                zero_flag,
	output cpu_pkg::flag_t                carry_flag,
	output logic                          halted
);

	typedef enum logic [2:0] {EX_IDLE, EX_MEM, EX_IN, EX_OUT, EX_HALT} exec_state_t;

	exec_state_t    state;
	exec_state_t    next_state;
	cpu_pkg::word_t alu_b;
	logic [8:0]     res;
	logic           acc_we;
	logic           c_we;
	// Where the program continues after the last finished instruction
	mem_pkg::addr_t resume_pc;
	mem_pkg::addr_t shadow_pc;
	cpu_pkg::word_t shadow_acc;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	// Memory byte replaces the immediate during a load
	assign alu_b = (state == EX_MEM) ? dc_rdata : operand;

	// Bit 8 is the carry out or the SUBI borrow
	always_comb begin
		case (opcode)
			cpu_pkg::ADDI, cpu_pkg::ADDM: res = {1'b0, acc} + {1'b0, alu_b};
			cpu_pkg::SUBI: res = {1'b0, acc} - {1'b0, alu_b};
			cpu_pkg::ANDI: res = {1'b0, acc & alu_b};
			cpu_pkg::ORI:  res = {1'b0, acc | alu_b};
			cpu_pkg::XORI: res = {1'b0, acc ^ alu_b};
			// Bit shifted out lands in the carry
			cpu_pkg::SHL:  res = {acc, 1'b0};
			cpu_pkg::SHR:  res = {acc[0], 1'b0, acc[7:1]};
			cpu_pkg::IN:   res = {1'b0, input_bus};
			cpu_pkg::RETI: res = {1'b0, shadow_acc};
			// LDI and LDM pass the operand through
			default:       res = {1'b0, alu_b};
		endcase
	end

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state  = state;
		instr_taken = 1'b0;
		redirect    = 1'b0;
		redirect_pc = operand;
		irq_ack     = 1'b0;
		irq_done    = 1'b0;
		mask_we     = 1'b0;
		acc_we      = 1'b0;
		c_we        = 1'b0;
		case (state)
			EX_IDLE: if (instr_valid) begin
				case (opcode)
					cpu_pkg::LDM, cpu_pkg::STM, cpu_pkg::ADDM: next_state = EX_MEM;
					cpu_pkg::IN:  next_state = EX_IN;
					cpu_pkg::OUT: next_state = EX_OUT;
					cpu_pkg::JMP: begin
						instr_taken = 1'b1;
						redirect    = 1'b1;
					end
					cpu_pkg::JZ: begin
						instr_taken = 1'b1;
						redirect    = zero_flag;
					end
					cpu_pkg::EI: begin
						instr_taken = 1'b1;
						mask_we     = 1'b1;
					end
					cpu_pkg::RETI: begin
						instr_taken = 1'b1;
						redirect    = 1'b1;
						redirect_pc = shadow_pc;
						irq_done    = 1'b1;
						acc_we      = 1'b1;
					end
					cpu_pkg::HALT: begin
						instr_taken = 1'b1;
						next_state  = EX_HALT;
					end
					cpu_pkg::LDI, cpu_pkg::ANDI, cpu_pkg::ORI, cpu_pkg::XORI: begin
						instr_taken = 1'b1;
						acc_we      = 1'b1;
					end
					cpu_pkg::ADDI, cpu_pkg::SUBI, cpu_pkg::SHL, cpu_pkg::SHR: begin
						instr_taken = 1'b1;
						acc_we      = 1'b1;
						c_we        = 1'b1;
					end
					default: instr_taken = 1'b1;
				endcase
			end else if (irq_pending) begin
				// Vector only between instructions
				redirect    = 1'b1;
				redirect_pc = mem_pkg::addr_t'(cpu_pkg::VECTOR_BASE +
					cpu_pkg::VECTOR_STRIDE * irq_level);
				irq_ack     = 1'b1;
			end
			EX_MEM: if (dc_done) begin
				instr_taken = 1'b1;
				next_state  = EX_IDLE;
				acc_we      = (opcode != cpu_pkg::STM);
				c_we        = (opcode == cpu_pkg::ADDM);
			end
			EX_IN: if (in_dev_hs) begin
				instr_taken = 1'b1;
				next_state  = EX_IDLE;
				acc_we      = 1'b1;
			end
			EX_OUT: if (out_dev_req && out_dev_ack) begin
				instr_taken = 1'b1;
				next_state  = EX_IDLE;
			end
			default: ;
		endcase
	end

	// Cache access follows the held instruction
	assign dc_req    = (state == EX_MEM);
	assign dc_we     = (opcode == cpu_pkg::STM);
	assign dc_addr   = operand;
	assign dc_wdata  = acc;
	assign mask_data = operand[cpu_pkg::IRQ_LINES-1:0];
	assign halted    = (state == EX_HALT);

	always_ff @(posedge g_clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= EX_IDLE;
			acc         <= '0;
			zero_flag   <= 1'b0;
			carry_flag  <= 1'b0;
			in_dev_ack  <= 1'b0;
			out_dev_req <= 1'b0;
			output_bus  <= '0;
			resume_pc   <= cpu_pkg::RESET_PC;
		end else begin
			state      <= next_state;
			in_dev_ack <= (state == EX_IN) && in_dev_hs;
			if (acc_we) begin
				acc       <= res[7:0];
				zero_flag <= (res[7:0] == '0);
			end
			if (c_we)
				carry_flag <= res[8];
			// Hold the byte and the request until the device takes it
			if (state == EX_OUT) begin
				if (!out_dev_req && out_dev_hs) begin
					output_bus  <= acc;
					out_dev_req <= 1'b1;
				end else if (out_dev_ack) begin
					out_dev_req <= 1'b0;
				end
			end
			// Jump target, vector or return address
			if (redirect)
				resume_pc <= redirect_pc;
			else if (instr_taken)
				resume_pc <= next_pc;
		end
	end

	// Shadow pair for the one active level
	always_ff @(posedge g_clk) begin
		if (irq_ack) begin
			shadow_pc  <= resume_pc;
			shadow_acc <= acc;
		end
	end

	a_instr_held: assert property (@(posedge g_clk) disable iff (!rst_n)
		(state == EX_MEM || state == EX_IN || state == EX_OUT) |-> instr_valid)
		else $error("held instruction dropped while executing");

endmodule

/* processor.sv */
`timescale 1ns/10ps

module processor (
	input  logic                          g_clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          load_en,
	input  mem_pkg::addr_t                load_addr,
	input  mem_pkg::mem_data_t            load_data,
	input  logic [cpu_pkg::IRQ_LINES-1:0] irq,
	input  logic                          in_dev_hs,
	input  cpu_pkg::word_t                input_bus,
	input  logic                          out_dev_hs,
	input  logic                          out_dev_ack,
	output logic                          in_dev_ack,
	output logic                          out_dev_req,
	output cpu_pkg::word_t                output_bus,
	output cpu_pkg::word_t                acc,
	output cpu_pkg::flag_t                zero_flag,
	output cpu_pkg::flag_t                carry_flag,
	output logic                          cache_hit,
	output logic                          halted
);

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////

	logic               dc_mem_req;
	logic               dc_mem_we;
	mem_pkg::addr_t     dc_mem_addr;
	mem_pkg::mem_data_t dc_mem_wdata;
	logic               dc_mem_gnt;
	logic               if_mem_req;
	mem_pkg::addr_t     if_mem_addr;
	logic               if_mem_gnt;
	logic               ram_we;
	mem_pkg::addr_t     ram_addr;
	mem_pkg::mem_data_t ram_wdata;
	// Shared by the cache and fetch
	mem_pkg::mem_data_t mem_rdata;

	////////////////////////////////////////////////////////////
	// Pipeline and cache
	////////////////////////////////////////////////////////////

	logic                          instr_valid;
	cpu_pkg::opcode_t              opcode;
	cpu_pkg::word_t                operand;
	mem_pkg::addr_t                next_pc;
	logic                          instr_taken;
	logic                          redirect;
	mem_pkg::addr_t                redirect_pc;
	logic                          dc_req;
	logic                          dc_we;
	mem_pkg::addr_t                dc_addr;
	mem_pkg::mem_data_t            dc_wdata;
	logic                          dc_done;
	mem_pkg::mem_data_t            dc_rdata;

	// Interrupt handshake
	logic                          irq_pending;
	cpu_pkg::irq_level_t           irq_level;
	logic                          irq_ack;
	logic                          irq_done;
	logic                          mask_we;
	logic [cpu_pkg::IRQ_LINES-1:0] mask_data;

	mem_arbiter u_arbiter (.*);

	unified_ram u_ram (
		.g_clk (g_clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (ram_wdata),
		.rdata (mem_rdata)
	);

	data_cache u_cache (.*);

	fetch_stage u_fetch (.*);

	interrupt_ctrl u_irq (.*);

	execute_stage u_execute (.*);

endmodule

/* tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////

task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		mismatch_count++;
	end
endtask

// Right-shifting Galois form with taps 8 6 5 4
function automatic logic [7:0] lfsr_next(input logic [7:0] s);
	return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [7:0] rand_byte();
	logic [7:0] b;
	b = '0;
	for (int i = 0; i < 8; i++) begin
		b = {b[6:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return b;
endfunction

task automatic emit_instr(input cpu_pkg::opcode_t op, input logic [7:0] arg);
	prog.push_back(op);
	prog.push_back(arg);
endtask

// Writes the pending bytes through the load port while run stays low
task automatic load_program(input mem_pkg::addr_t base);
	for (int i = 0; i < prog.size(); i++) begin
		@(posedge g_clk);
		load_en   <= 1'b1;
		load_addr <= mem_pkg::addr_t'(base + i);
		load_data <= prog[i];
	end
	@(posedge g_clk);
	load_en <= 1'b0;
	prog.delete();
endtask

task automatic apply_reset();
	@(posedge g_clk);
	rst_n   <= 1'b0;
	run     <= 1'b0;
	load_en <= 1'b0;
	irq     <= '0;
	repeat (3) @(posedge g_clk);
	rst_n      <= 1'b1;
	out_dev_hs <= 1'b1;
endtask

// Fresh DUT and empty logs
task automatic start_test();
	apply_reset();
	prog.delete();
	exp_out.delete();
	exp_carry.delete();
	exp_zero.delete();
	exp_hit.delete();
	out_log.delete();
	carry_log.delete();
	zero_log.delete();
	hit_log.delete();
	in_script.delete();
	out_delay = 0;
endtask

task automatic run_until_halt(input string name, input int budget);
	int cycles;
	cycles = 0;
	@(posedge g_clk);
	run <= 1'b1;
	@(negedge g_clk);
	while (!halted && cycles < budget) begin
		@(negedge g_clk);
		cycles++;
	end
	if (!halted) begin
		$display("%s: processor did not halt within %0d cycles", name, budget);
		fail_count++;
	end
	@(posedge g_clk);
	run <= 1'b0;
endtask

// Output bytes in order with carry, zero and hit where expected
task automatic compare_outputs(input string name);
	compare_value({name, " output count"}, 32'(exp_out.size()), 32'(out_log.size()));
	for (int i = 0; i < exp_out.size() && i < out_log.size(); i++) begin
		compare_value($sformatf("%s out[%0d]", name, i), 32'(exp_out[i]), 32'(out_log[i]));
		if (i < exp_carry.size())
			compare_value($sformatf("%s carry[%0d]", name, i),
				32'(exp_carry[i]), 32'(carry_log[i]));
		if (i < exp_zero.size())
			compare_value($sformatf("%s zero[%0d]", name, i),
				32'(exp_zero[i]), 32'(zero_log[i]));
		if (i < exp_hit.size())
			compare_value($sformatf("%s hit[%0d]", name, i), 32'(exp_hit[i]), 32'(hit_log[i]));
	end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

// ALU op followed by OUT of the result
task automatic queue_alu_op(input cpu_pkg::opcode_t op, input logic [7:0] arg,
		input logic [7:0] result, input logic carry);
	emit_instr(op, arg);
	emit_instr(cpu_pkg::OUT, 8'h00);
	exp_out.push_back(result);
	exp_carry.push_back(carry);
	exp_zero.push_back(result == 8'h00);
endtask

task automatic alu_sequence();
	logic [7:0] a;
	logic [7:0] b;
	logic [8:0] wide;
	logic       c;
	for (int round = 0; round < ALU_ROUNDS; round++) begin
		start_test();
		// Carry is clear after reset and LDI leaves it alone
		c = 1'b0;
		a = rand_byte();
		queue_alu_op(cpu_pkg::LDI, a, a, c);
		b = rand_byte();
		wide = {1'b0, a} + {1'b0, b};
		a = wide[7:0];
		c = wide[8];
		queue_alu_op(cpu_pkg::ADDI, b, a, c);
		// Borrow sets carry
		b = rand_byte();
		c = (a < b);
		a = a - b;
		queue_alu_op(cpu_pkg::SUBI, b, a, c);
		b = rand_byte();
		a = a & b;
		queue_alu_op(cpu_pkg::ANDI, b, a, c);
		b = rand_byte();
		a = a | b;
		queue_alu_op(cpu_pkg::ORI, b, a, c);
		b = rand_byte();
		a = a ^ b;
		queue_alu_op(cpu_pkg::XORI, b, a, c);
		// Shifted-out bit goes to carry
		c = a[7];
		a = {a[6:0], 1'b0};
		queue_alu_op(cpu_pkg::SHL, 8'h00, a, c);
		c = a[0];
		a = {1'b0, a[7:1]};
		queue_alu_op(cpu_pkg::SHR, 8'h00, a, c);
		// Clearing the accumulator sets Z
		b = a;
		a = a ^ b;
		queue_alu_op(cpu_pkg::XORI, b, a, c);
		emit_instr(cpu_pkg::HALT, 8'h00);
		load_program(cpu_pkg::RESET_PC);
		run_until_halt("alu", ALU_BUDGET);
		compare_outputs("alu");
	end
endtask

task automatic cache_eviction();
	mem_pkg::addr_t addrs [5];
	logic [7:0]     vals [5];
	int             order [8];
	logic [7:0]     hit_mask;
	start_test();
	addrs = '{8'h80, 8'h91, 8'hA2, 8'hB3, 8'hC4};
	// Repeat of 0x80 hits and four fills later 0x80 is gone
	order = '{0, 0, 1, 2, 3, 4, 0, 4};
	hit_mask = 8'b1000_0010;
	// Stores miss and do not allocate
	for (int i = 0; i < 5; i++) begin
		vals[i] = rand_byte();
		emit_instr(cpu_pkg::LDI, vals[i]);
		emit_instr(cpu_pkg::STM, addrs[i]);
	end
	for (int i = 0; i < 8; i++) begin
		emit_instr(cpu_pkg::LDM, addrs[order[i]]);
		emit_instr(cpu_pkg::OUT, 8'h00);
		exp_out.push_back(vals[order[i]]);
		exp_hit.push_back(hit_mask[i]);
	end
	emit_instr(cpu_pkg::HALT, 8'h00);
	load_program(cpu_pkg::RESET_PC);
	run_until_halt("cache", MEM_BUDGET);
	compare_outputs("cache");
endtask

task automatic countdown_loop();
	start_test();
	emit_instr(cpu_pkg::LDI, 8'd3);
	// Loop body at 0x02
	emit_instr(cpu_pkg::OUT, 8'h00);
	emit_instr(cpu_pkg::SUBI, 8'd1);
	emit_instr(cpu_pkg::JZ, 8'h0A);
	emit_instr(cpu_pkg::JMP, 8'h02);
	// Jump over the dead OUT at 0x0C
	emit_instr(cpu_pkg::JMP, 8'h0E);
	emit_instr(cpu_pkg::OUT, 8'h00);
	emit_instr(cpu_pkg::LDI, 8'h77);
	emit_instr(cpu_pkg::OUT, 8'h00);
	emit_instr(cpu_pkg::HALT, 8'h00);
	// Zero ends the loop before its OUT
	for (int n = 3; n > 0; n--)
		exp_out.push_back(8'(n));
	exp_out.push_back(8'h77);
	load_program(cpu_pkg::RESET_PC);
	run_until_halt("branch", BRANCH_BUDGET);
	compare_outputs("branch");
endtask

task automatic device_backpressure();
	start_test();
	// Slow output device
	out_delay = 6;
	for (int i = 0; i < 4; i++) begin
		in_script.push_back(rand_byte());
		emit_instr(cpu_pkg::IN, 8'h00);
		emit_instr(cpu_pkg::OUT, 8'h00);
		exp_out.push_back(in_script[i]);
	end
	emit_instr(cpu_pkg::HALT, 8'h00);
	load_program(cpu_pkg::RESET_PC);
	run_until_halt("io", IO_BUDGET);
	compare_outputs("io");
	compare_value("io inputs consumed", 32'd4, 32'(in_idx));
endtask

task automatic interrupt_return();
	start_test();
	// Each level outputs 0xA0 plus its level and returns
	for (int lvl = 0; lvl < cpu_pkg::IRQ_LINES; lvl++) begin
		emit_instr(cpu_pkg::LDI, 8'(8'hA0 + lvl));
		emit_instr(cpu_pkg::OUT, 8'h00);
		emit_instr(cpu_pkg::RETI, 8'h00);
		load_program(mem_pkg::addr_t'(cpu_pkg::VECTOR_BASE + 8 * lvl));
	end
	emit_instr(cpu_pkg::LDI, 8'h5A);
	emit_instr(cpu_pkg::EI, 8'b0000_0110);
	emit_instr(cpu_pkg::OUT, 8'h00);
	emit_instr(cpu_pkg::HALT, 8'h00);
	load_program(cpu_pkg::RESET_PC);
	// Lines 1 to 3 rise before EI while line 3 stays masked
	@(posedge g_clk);
	irq <= 4'b1110;
	exp_out.push_back(8'hA1);
	exp_out.push_back(8'hA2);
	exp_out.push_back(8'h5A);
	run_until_halt("irq", IRQ_BUDGET);
	compare_outputs("irq");
	compare_value("irq acc", 32'h5A, 32'(acc));
endtask

`endif

/* tb_processor.sv */
`timescale 1ns/10ps

module tb_processor;

	localparam int CLK_PERIOD = 100;

	// Cycle budgets for one program run each
	localparam int ALU_ROUNDS    = 2;
	localparam int ALU_BUDGET    = 400;
	localparam int MEM_BUDGET    = 800;
	localparam int BRANCH_BUDGET = 600;
	localparam int IO_BUDGET     = 600;
	localparam int IRQ_BUDGET    = 600;
	// Extra room for reset and program loading
	localparam int WATCHDOG_CYCLES = ALU_ROUNDS * ALU_BUDGET + MEM_BUDGET + BRANCH_BUDGET +
		IO_BUDGET + IRQ_BUDGET + 1000;

	////////////////////////////////////////////////////////////
	// DUT ports
	////////////////////////////////////////////////////////////

	logic                          g_clk;
	logic                          rst_n;
	logic                          run;
	logic                          load_en;
	mem_pkg::addr_t                load_addr;
	mem_pkg::mem_data_t            load_data;
	logic [cpu_pkg::IRQ_LINES-1:0] irq;
	logic                          in_dev_hs;
	cpu_pkg::word_t                input_bus;
	logic                          out_dev_hs;
	logic                          out_dev_ack;
	logic                          in_dev_ack;
	logic                          out_dev_req;
	cpu_pkg::word_t                output_bus;
	cpu_pkg::word_t                acc;
	cpu_pkg::flag_t                zero_flag;
	cpu_pkg::flag_t                carry_flag;
	logic                          cache_hit;
	logic                          halted;

	////////////////////////////////////////////////////////////
	// Test bookkeeping
	////////////////////////////////////////////////////////////

	int mismatch_count = 0;
	int fail_count = 0;

	// Program bytes waiting for the load port
	logic [7:0] prog [$];

	// Expected and observed output events
	logic [7:0] exp_out [$];
	logic       exp_carry [$];
	logic       exp_zero [$];
	logic       exp_hit [$];
	logic [7:0] out_log [$];
	logic       carry_log [$];
	logic       zero_log [$];
	logic       hit_log [$];

	// Device model state
	logic [7:0] in_script [$];
	int         in_idx;
	int         out_delay;
	int         out_wait;
	logic       hit_flag;

	logic [7:0] lfsr_state = 8'd28;

	processor dut (.*);

	initial begin
		g_clk = 1'b0;
		forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
	end

	// Hard stop if a test sequence hangs
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, test sequence hung", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Device models
	////////////////////////////////////////////////////////////

	// Input device offers the next scripted byte
	// Moves on after each in_dev_ack
	always @(posedge g_clk) begin
		if (!rst_n) begin
			in_idx = 0;
			in_dev_hs <= 1'b0;
		end else begin
			if (in_dev_ack)
				in_idx = in_idx + 1;
			in_dev_hs <= (in_idx < in_script.size());
			input_bus <= (in_idx < in_script.size()) ? in_script[in_idx] : 8'h00;
		end
	end

	// Output device waits out_delay cycles before it logs the byte and acks
	always @(posedge g_clk) begin
		if (!rst_n) begin
			out_dev_ack <= 1'b0;
			out_wait = 0;
			hit_flag = 1'b0;
		end else begin
			// Any read hit since the last output
			if (cache_hit)
				hit_flag = 1'b1;
			if (out_dev_ack) begin
				out_dev_ack <= 1'b0;
			end else if (out_dev_req) begin
				if (out_wait >= out_delay) begin
					out_log.push_back(output_bus);
					carry_log.push_back(carry_flag);
					zero_log.push_back(zero_flag);
					hit_log.push_back(hit_flag);
					hit_flag = 1'b0;
					out_wait = 0;
					out_dev_ack <= 1'b1;
				end else begin
					out_wait = out_wait + 1;
				end
			end
		end
	end

	`include "tb_tasks.svh"

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		irq = '0;
		in_dev_hs = 1'b0;
		input_bus = '0;
		out_dev_hs = 1'b0;
		out_dev_ack = 1'b0;
		out_delay = 0;

		alu_sequence();
		cache_eviction();
		countdown_loop();
		device_backpressure();
		interrupt_return();

		$display("tb_processor finished with %0d mismatches and %0d other errors",
			mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
mem_pkg.sv
cpu_pkg.sv
mem_arbiter.sv
unified_ram.sv
data_cache.sv
fetch_stage.sv
interrupt_ctrl.sv
execute_stage.sv
processor.sv
tb_processor.sv
